/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic [data_width-1:0] a,
   input  logic [data_width-1:0] b,
   input  alu_pkg::func_t        func_code,
   input  alu_pkg::branch_t      branch_type,
   output logic [data_width-1:0] c,
   output logic                  overflow_flag,
   output logic                  bcond
);

   import alu_pkg::*;

   localparam int msb = data_width - 1; // sign bit

   always_comb begin
      c             = '0;
      overflow_flag = 1'b0;
      bcond         = 1'b0; // only branches set it

      case (func_code)
         func_add: begin
            c = a + b;
            // same-sign operands, result sign flipped
            overflow_flag = (a[msb] == b[msb]) && (a[msb] != c[msb]);
         end
         func_sub: begin
            c = a - b;
            overflow_flag = (a[msb] != b[msb]) && (a[msb] != c[msb]);
         end
         func_and: c = a & b;
         func_orr: c = a | b;
         func_not: c = ~a;
         func_tcp: c = ~a + 1'b1;
         func_shl: c = {a[msb-1:0], 1'b0};
         func_shr: c = {a[msb], a[msb:1]}; // keep sign
         func_id1: c = a;
         func_id2: c = b;
         func_bxx: begin
            case (branch_type)
               br_ne:   bcond = (a != b);
               br_eq:   bcond = (a == b);
               br_gz:   bcond = !a[msb] && (a != '0);
               br_lz:   bcond = a[msb];
               default: bcond = 1'b0;
            endcase
            c = {{(data_width-1){1'b0}}, bcond}; // condition in bit 0
         end
         default: begin
            c             = '0; // undefined code
            overflow_flag = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

   localparam int num_bits = 16; // one machine word

   typedef logic [num_bits-1:0] data_t;

   typedef logic [3:0] func_t;

   localparam func_t func_add = 4'h0; // a + b
   localparam func_t func_sub = 4'h1; // a - b
   localparam func_t func_and = 4'h2;
   localparam func_t func_orr = 4'h3;
   localparam func_t func_not = 4'h4; // ~a
   localparam func_t func_tcp = 4'h5; // two's complement of a
   localparam func_t func_shl = 4'h6; // arithmetic shift left
   localparam func_t func_shr = 4'h7; // arithmetic shift right
   localparam func_t func_id1 = 4'h8; // pass a
   localparam func_t func_id2 = 4'h9; // pass b
   localparam func_t func_bxx = 4'ha; // branch test, see branch_t

   typedef logic [1:0] branch_t;

   localparam branch_t br_ne = 2'd0; // a != b
   localparam branch_t br_eq = 2'd1; // a == b
   localparam branch_t br_gz = 2'd2; // a > 0
   localparam branch_t br_lz = 2'd3; // a < 0

endpackage

`default_nettype wire

/* cmd_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_receiver #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    cmd_req,
   input  alu_pkg::func_t          cmd_func,
   input  alu_pkg::branch_t        cmd_branch,
   input  exec_pkg::reg_idx_t      cmd_rs,
   input  exec_pkg::reg_idx_t      cmd_rt,
   input  exec_pkg::reg_idx_t      cmd_rd,
   input  logic                    cmd_use_imm,
   input  logic [data_width-1:0]   cmd_imm,
   input  logic                    cmd_taken,
   output logic                    cmd_ack,
   output logic                    cmd_valid,
   output alu_pkg::func_t          q_func,
   output alu_pkg::branch_t        q_branch,
   output exec_pkg::reg_idx_t      q_rs,
   output exec_pkg::reg_idx_t      q_rt,
   output exec_pkg::reg_idx_t      q_rd,
   output logic                    q_use_imm,
   output logic [data_width-1:0]   q_imm
);

   typedef enum logic [1:0] {st_idle, st_acked, st_wait_free} rx_state_t;

   rx_state_t state;
   logic      full;  // holding register occupied
   logic      load;

   // accept only into an empty holding register
   assign load = !full && ((state == st_idle && cmd_req) || state == st_wait_free);

   assign cmd_valid = full;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= st_idle;
         cmd_ack <= 1'b0;
         full    <= 1'b0;
      end else begin
         if (cmd_taken)
            full <= 1'b0; // core owns the command now
         case (state)
            st_idle: begin
               if (cmd_req) begin
                  if (load) begin
                     full    <= 1'b1;
                     cmd_ack <= 1'b1;
                     state   <= st_acked;
                  end else begin
                     state <= st_wait_free; // back-pressure, hold ack low
                  end
               end
            end
            st_wait_free: begin
               if (load) begin
                  full    <= 1'b1;
                  cmd_ack <= 1'b1;
                  state   <= st_acked;
               end
            end
            st_acked: begin
               if (!cmd_req) begin
                  cmd_ack <= 1'b0; // return to zero
                  state   <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         q_func    <= cmd_func;
         q_branch  <= cmd_branch;
         q_rs      <= cmd_rs;
         q_rt      <= cmd_rt;
         q_rd      <= cmd_rd;
         q_use_imm <= cmd_use_imm;
         q_imm     <= cmd_imm;
      end
   end

endmodule

`default_nettype wire

/* compile.f */
alu_pkg.sv
exec_pkg.sv
alu.sv
reg_file.sv
cmd_receiver.sv
exec_core.sv
result_sender.sv
exec_unit_top.sv
tb_exec_unit.sv

/* exec_core.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_core #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   input  alu_pkg::func_t        q_func,
   input  alu_pkg::branch_t      q_branch,
   input  exec_pkg::reg_idx_t    q_rs,
   input  exec_pkg::reg_idx_t    q_rt,
   input  exec_pkg::reg_idx_t    q_rd,
   input  logic                  q_use_imm,
   input  logic [data_width-1:0] q_imm,
   input  logic [data_width-1:0] rd_data_a,
   input  logic [data_width-1:0] rd_data_b,
   input  logic                  send_done,
   output logic                  cmd_taken,
   output exec_pkg::reg_idx_t    rd_addr_a,
   output exec_pkg::reg_idx_t    rd_addr_b,
   output logic                  wr_en,
   output exec_pkg::reg_idx_t    wr_addr,
   output logic [data_width-1:0] wr_data,
   output logic                  send_valid,
   output logic [data_width-1:0] res_c,
   output logic                  res_overflow,
   output logic                  res_bcond
);

   import alu_pkg::*;
   import exec_pkg::*;

   typedef enum logic {st_wait_cmd, st_reply} core_state_t;

   core_state_t           state;
   logic [data_width-1:0] opnd_b;
   logic [data_width-1:0] alu_c;
   logic                  alu_ovf;
   logic                  alu_bcond;
   func_t                 func_r;   // kept for the write-back decision
   reg_idx_t              rd_r;

   assign cmd_taken = (state == st_wait_cmd) && cmd_valid;

   assign rd_addr_a = q_rs;
   assign rd_addr_b = q_rt;
   assign opnd_b    = q_use_imm ? q_imm : rd_data_b; // immediate replaces rt

   alu #(
      .data_width (data_width)
   ) alu_i (
      .a             (rd_data_a),
      .b             (opnd_b),
      .func_code     (q_func),
      .branch_type   (q_branch),
      .c             (alu_c),
      .overflow_flag (alu_ovf),
      .bcond         (alu_bcond)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= st_wait_cmd;
         send_valid <= 1'b0;
      end else begin
         case (state)
            st_wait_cmd: begin
               if (cmd_valid) begin
                  send_valid <= 1'b1;
                  state      <= st_reply;
               end
            end
            st_reply: begin
               if (send_done) begin
                  send_valid <= 1'b0; // next command one clk later
                  state      <= st_wait_cmd;
               end
            end
            default: state <= st_wait_cmd;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_taken) begin
         res_c        <= alu_c;
         res_overflow <= alu_ovf;
         res_bcond    <= alu_bcond;
         func_r       <= q_func;
         rd_r         <= q_rd;
      end
   end

   // registers change only once the reply is consumed
   assign wr_en   = (state == st_reply) && send_done && writes_reg(func_r);
   assign wr_addr = rd_r;
   assign wr_data = res_c;

endmodule

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

   localparam int reg_count = 4; // four-register machine

   typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

   // write-back rule per function code
   function automatic logic writes_reg(input alu_pkg::func_t func);
      logic wr;
      case (func)
         alu_pkg::func_bxx: wr = 1'b0; // branches only report bcond
         default:           wr = 1'b1;
      endcase
      return wr;
   endfunction

endpackage

`default_nettype wire

/* exec_stim.txt */
# name func branch rs rt rd use_imm imm exp_c exp_ovf exp_bcond slow (all hex)
# func 0 add 1 sub 2 and 3 orr 4 not 5 tcp 6 shl 7 shr 8 id1 9 id2 a bxx
rst_r0 8 0 0 0 0 0 0000 0000 0 0 0
rst_r1 8 0 1 0 1 0 0000 0000 0 0 0
rst_r2 8 0 2 0 2 0 0000 0000 0 0 0
rst_r3 8 0 3 0 3 0 0000 0000 0 0 0
ld_r0 9 0 0 0 0 1 7fff 7fff 0 0 0
ld_r1 9 0 0 0 1 1 0001 0001 0 0 0
ld_r2 9 0 0 0 2 1 8000 8000 0 0 0
ld_r3 9 0 0 0 3 1 1234 1234 0 0 0
rd_r3 8 0 3 0 3 0 0000 1234 0 0 0
add_ok 0 0 3 1 3 0 0000 1235 0 0 0
add_ovf 0 0 0 1 3 0 0000 8000 1 0 0
sub_ok 1 0 3 2 3 0 0000 0000 0 0 0
sub_ovf 1 0 2 1 3 0 0000 7fff 1 0 0
tcp_min 5 0 2 0 3 0 0000 8000 0 0 0
and_imm 2 0 0 0 3 1 0f0f 0f0f 0 0 0
orr_imm 3 0 3 0 3 1 f000 ff0f 0 0 0
not_r3 4 0 3 0 3 0 0000 00f0 0 0 0
shl_r3 6 0 3 0 3 0 0000 01e0 0 0 0
shr_neg 7 0 2 0 3 0 0000 c000 0 0 0
bne_diff a 0 0 1 3 0 0000 0001 0 1 0
bne_same a 0 1 1 3 0 0000 0000 0 0 0
beq_same a 1 2 2 3 0 0000 0001 0 1 0
beq_diff a 1 0 2 3 0 0000 0000 0 0 0
bgz_pos a 2 1 0 3 0 0000 0001 0 1 0
bgz_neg a 2 2 0 3 0 0000 0000 0 0 0
blz_neg a 3 3 0 3 0 0000 0001 0 1 0
blz_pos a 3 0 0 3 0 0000 0000 0 0 0
chk_r3 8 0 3 0 3 0 0000 c000 0 0 0
ld_zero 9 0 0 0 1 1 0000 0000 0 0 0
bgz_zero a 2 1 0 3 0 0000 0000 0 0 0
beq_imm a 1 1 0 3 1 0000 0001 0 1 0
bp_ld 9 0 0 0 2 1 0005 0005 0 0 1
bp_add 0 0 2 2 2 0 0000 000a 0 0 1
bp_add2 0 0 2 2 2 0 0000 0014 0 0 1
bp_sub 1 0 1 2 2 0 0000 ffec 0 0 1
bp_shr 7 0 2 0 2 0 0000 fff6 0 0 1
bp_chk 8 0 2 0 0 0 0000 fff6 0 0 1

/* exec_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit_top #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_req,
   input  alu_pkg::func_t        cmd_func,
   input  alu_pkg::branch_t      cmd_branch,
   input  exec_pkg::reg_idx_t    cmd_rs,
   input  exec_pkg::reg_idx_t    cmd_rt,
   input  exec_pkg::reg_idx_t    cmd_rd,
   input  logic                  cmd_use_imm,
   input  logic [data_width-1:0] cmd_imm,
   output logic                  cmd_ack,
   output logic                  res_req,
   output logic [data_width-1:0] res_data,
   output logic                  res_overflow,
   output logic                  res_bcond,
   input  logic                  res_ack
);

   import alu_pkg::*;
   import exec_pkg::*;

   logic                  cmd_valid, cmd_taken;
   func_t                 q_func;
   branch_t               q_branch;
   reg_idx_t              q_rs, q_rt, q_rd;
   logic                  q_use_imm;
   logic [data_width-1:0] q_imm;
   reg_idx_t              rd_addr_a, rd_addr_b, wr_addr;
   logic [data_width-1:0] rd_data_a, rd_data_b, wr_data;
   logic                  wr_en;
   logic                  send_valid, send_done;
   logic [data_width-1:0] core_c;  // result held by the core
   logic                  core_overflow, core_bcond;

   cmd_receiver #(.data_width(data_width)) receiver_i (
      .clk(clk), .rst_n(rst_n),
      .cmd_req(cmd_req), .cmd_func(cmd_func), .cmd_branch(cmd_branch),
      .cmd_rs(cmd_rs), .cmd_rt(cmd_rt), .cmd_rd(cmd_rd),
      .cmd_use_imm(cmd_use_imm), .cmd_imm(cmd_imm),
      .cmd_taken(cmd_taken), .cmd_ack(cmd_ack), .cmd_valid(cmd_valid),
      .q_func(q_func), .q_branch(q_branch), .q_rs(q_rs), .q_rt(q_rt),
      .q_rd(q_rd), .q_use_imm(q_use_imm), .q_imm(q_imm)
   );

   reg_file #(.data_width(data_width)) regs_i (
      .clk(clk), .rst_n(rst_n),
      .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
   );

   exec_core #(.data_width(data_width)) core_i (
      .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid),
      .q_func(q_func), .q_branch(q_branch), .q_rs(q_rs), .q_rt(q_rt),
      .q_rd(q_rd), .q_use_imm(q_use_imm), .q_imm(q_imm),
      .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .send_done(send_done),
      .cmd_taken(cmd_taken), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .send_valid(send_valid), .res_c(core_c),
      .res_overflow(core_overflow), .res_bcond(core_bcond)
   );

   result_sender #(.data_width(data_width)) sender_i (
      .clk(clk), .rst_n(rst_n), .send_valid(send_valid),
      .res_c(core_c), .res_overflow(core_overflow), .res_bcond(core_bcond),
      .res_ack(res_ack), .send_done(send_done), .res_req(res_req),
      .res_data(res_data), .res_overflow_out(res_overflow),
      .res_bcond_out(res_bcond)
   );

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  exec_pkg::reg_idx_t    rd_addr_a,
   input  exec_pkg::reg_idx_t    rd_addr_b,
   input  logic                  wr_en,
   input  exec_pkg::reg_idx_t    wr_addr,
   input  logic [data_width-1:0] wr_data,
   output logic [data_width-1:0] rd_data_a,
   output logic [data_width-1:0] rd_data_b
);

   import exec_pkg::*;

   logic [data_width-1:0] regs [reg_count];

   // the machine starts from all-zero registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   assign rd_data_a = regs[rd_addr_a]; // async read
   assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

/* result_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module result_sender #(
   parameter int data_width = alu_pkg::num_bits
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  send_valid,
   input  logic [data_width-1:0] res_c,
   input  logic                  res_overflow,
   input  logic                  res_bcond,
   input  logic                  res_ack,
   output logic                  send_done,
   output logic                  res_req,
   output logic [data_width-1:0] res_data,
   output logic                  res_overflow_out,
   output logic                  res_bcond_out
);

   typedef enum logic [1:0] {st_idle, st_req, st_release, st_done} tx_state_t;

   tx_state_t state;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= st_idle;
         res_req   <= 1'b0;
         send_done <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (send_valid) begin
                  res_req <= 1'b1;
                  state   <= st_req;
               end
            end
            st_req: begin
               if (res_ack) begin
                  res_req <= 1'b0;
                  state   <= st_release;
               end
            end
            st_release: begin
               if (!res_ack) begin
                  send_done <= 1'b1; // one-clk pulse
                  state     <= st_done;
               end
            end
            st_done: begin
               // gives the core a clk to drop send_valid
               send_done <= 1'b0;
               state     <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && send_valid) begin
         res_data         <= res_c;
         res_overflow_out <= res_overflow;
         res_bcond_out    <= res_bcond;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_exec_unit -f compile.f -o tb_exec_unit_sim

./obj_dir/tb_exec_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0

/* tb_exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_unit;

   import alu_pkg::*;
   import exec_pkg::*;

   localparam int max_tests  = 64;
   localparam int wait_limit = 400; // cycles allowed per handshake edge

   logic     clk = 1'b0;
   logic     rst_n;
   logic     cmd_req;
   func_t    cmd_func;
   branch_t  cmd_branch;
   reg_idx_t cmd_rs, cmd_rt, cmd_rd;
   logic     cmd_use_imm;
   data_t    cmd_imm;
   logic     cmd_ack;
   logic     res_req;
   data_t    res_data;
   logic     res_overflow, res_bcond;
   logic     res_ack;

   // one row of the stimulus file per entry
   string    t_name [max_tests];
   func_t    t_func [max_tests];
   branch_t  t_branch [max_tests];
   reg_idx_t t_rs [max_tests];
   reg_idx_t t_rt [max_tests];
   reg_idx_t t_rd [max_tests];
   logic     t_use_imm [max_tests];
   data_t    t_imm [max_tests];
   data_t    t_exp_c [max_tests];
   logic     t_exp_ovf [max_tests];
   logic     t_exp_bcond [max_tests];
   logic     t_slow [max_tests]; // long res_ack delays

   int       n_tests = 0;
   int       passes = 0;
   int       failures = 0;
   int       errors = 0;  // handshake and reset checks
   int       acked = 0;
   int       seen = 0;
   logic     aborted = 1'b0;

   exec_unit_top dut_i (
      .clk(clk), .rst_n(rst_n),
      .cmd_req(cmd_req), .cmd_func(cmd_func), .cmd_branch(cmd_branch),
      .cmd_rs(cmd_rs), .cmd_rt(cmd_rt), .cmd_rd(cmd_rd),
      .cmd_use_imm(cmd_use_imm), .cmd_imm(cmd_imm), .cmd_ack(cmd_ack),
      .res_req(res_req), .res_data(res_data), .res_overflow(res_overflow),
      .res_bcond(res_bcond), .res_ack(res_ack)
   );

   always #20 clk = ~clk;

   task automatic next_cycle;
      @(posedge clk);
      #5; // drive and sample point
   endtask

   task automatic idle_cycles(input int max_n);
      int n;
      n = int'($urandom % (max_n + 1));
      repeat (n) next_cycle();
   endtask

   // polls cmd_ack or res_req until it reaches level
   task automatic wait_level(input bit on_res, input logic level, input string what);
      int cycles;
      cycles = 0;
      while (((on_res ? res_req : cmd_ack) !== level) && !aborted) begin
         next_cycle();
         cycles++;
         if (cycles >= wait_limit) begin
            $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
            aborted = 1'b1;
         end
      end
   endtask

   function automatic int first_space(input string s);
      for (int k = 0; k < s.len(); k++) begin
         if (s.getc(k) == " ")
            return k;
      end
      return s.len();
   endfunction

   task automatic load_stimulus;
      int    fd, n, sp;
      string line, fields;
      int    f, br, rs, rt, rd, ui, imm, ec, eo, eb, sl;
      fd = $fopen("exec_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open exec_stim.txt");
         aborted = 1'b1;
      end else begin
         while (!$feof(fd) && n_tests < max_tests) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
               sp = first_space(line);
               fields = line.substr(sp, line.len() - 1);
               n = $sscanf(fields, "%h %h %h %h %h %h %h %h %h %h %h",
                           f, br, rs, rt, rd, ui, imm, ec, eo, eb, sl);
               if (n == 11) begin
                  t_name[n_tests]      = line.substr(0, sp - 1);
                  t_func[n_tests]      = f[3:0];
                  t_branch[n_tests]    = br[1:0];
                  t_rs[n_tests]        = rs[1:0];
                  t_rt[n_tests]        = rt[1:0];
                  t_rd[n_tests]        = rd[1:0];
                  t_use_imm[n_tests]   = ui[0];
                  t_imm[n_tests]       = imm[15:0];
                  t_exp_c[n_tests]     = ec[15:0];
                  t_exp_ovf[n_tests]   = eo[0];
                  t_exp_bcond[n_tests] = eb[0];
                  t_slow[n_tests]      = sl[0];
                  n_tests++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic send_commands;
      for (int i = 0; i < n_tests && !aborted; i++) begin
         idle_cycles(5);
         cmd_func    = t_func[i];
         cmd_branch  = t_branch[i];
         cmd_rs      = t_rs[i];
         cmd_rt      = t_rt[i];
         cmd_rd      = t_rd[i];
         cmd_use_imm = t_use_imm[i];
         cmd_imm     = t_imm[i];
         cmd_req     = 1'b1;
         wait_level(1'b0, 1'b1, "cmd_ack rise");
         if (!aborted) begin
            acked++;
            // at most one reply in flight plus one held command
            assert (acked - seen <= 2) else begin
               $display("ERR %0t: cmd_ack for %s with %0d replies pending",
                        $time, t_name[i], acked - seen - 1);
               errors++;
            end
         end
         cmd_req = 1'b0;
         wait_level(1'b0, 1'b0, "cmd_ack fall");
      end
   endtask

   task automatic check_reply(input int i);
      bit ok;
      ok = 1'b1;
      assert (res_data === t_exp_c[i]) else begin
         $display("ERR %0t: %s c is %h, expected %h", $time, t_name[i], res_data, t_exp_c[i]);
         ok = 1'b0;
      end
      assert (res_overflow === t_exp_ovf[i]) else begin
         $display("ERR %0t: %s overflow is %b, expected %b",
                  $time, t_name[i], res_overflow, t_exp_ovf[i]);
         ok = 1'b0;
      end
      assert (res_bcond === t_exp_bcond[i]) else begin
         $display("ERR %0t: %s bcond is %b, expected %b",
                  $time, t_name[i], res_bcond, t_exp_bcond[i]);
         ok = 1'b0;
      end
      if (ok)
         passes++;
      else
         failures++;
      $display("test %s: %s", t_name[i], ok ? "pass" : "fail");
   endtask

   task automatic collect_replies;
      for (int i = 0; i < n_tests && !aborted; i++) begin
         wait_level(1'b1, 1'b1, "res_req rise");
         if (!aborted) begin
            seen++;
            check_reply(i);
            idle_cycles(t_slow[i] ? 20 : 5);
            res_ack = 1'b1;
            wait_level(1'b1, 1'b0, "res_req fall");
            idle_cycles(t_slow[i] ? 20 : 5);
            res_ack = 1'b0;
         end
      end
   endtask

   initial begin
      void'($urandom(32'he6c6_1ee2));
      rst_n       = 1'b0;
      cmd_req     = 1'b0;
      cmd_func    = '0;
      cmd_branch  = '0;
      cmd_rs      = '0;
      cmd_rt      = '0;
      cmd_rd      = '0;
      cmd_use_imm = 1'b0;
      cmd_imm     = '0;
      res_ack     = 1'b0;
      load_stimulus();
      repeat (2) @(posedge clk);
      #5 rst_n = 1'b1;
      assert (res_req === 1'b0 && cmd_ack === 1'b0) else begin
         $display("ERR %0t: res_req %b cmd_ack %b after reset", $time, res_req, cmd_ack);
         errors++;
      end
      fork
         send_commands();
         collect_replies();
      join
      $display("%0d of %0d tests passed, %0d failed, %0d handshake errors",
               passes, n_tests, failures, errors);
      if (failures == 0 && errors == 0 && !aborted && n_tests > 0 && passes == n_tests)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
